/* shader_defines.svh */
`ifndef SHADER_DEFINES_SVH
`define SHADER_DEFINES_SVH

// ray pool and queue sizing
`define NUM_RAYS          16
`define RESULT_FIFO_DEPTH 4

// 24-bit rgb colors
`define MISS_COLOR        24'h101828
`define TRI_0_COLOR       24'hff0000
`define TRI_1_COLOR       24'h00ff00
`define TRI_2_COLOR       24'h0000ff
`define TRI_3_COLOR       24'hffff00
// any hit outside triangles 0 to 3
`define OTHER_HIT_COLOR   24'hffffff

`endif

/* ray_types_pkg.sv */
`default_nettype none

`include "shader_defines.svh"

package ray_types_pkg;

  // slot in the ray pool
  typedef logic [$clog2(`NUM_RAYS)-1:0] ray_id_t;
  typedef logic [15:0] pixel_id_t;
  typedef logic [15:0] tri_id_t;
  typedef logic [15:0] coord_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } vec3_t;

  // origin and direction, 96 bits
  typedef struct packed {
    vec3_t origin;
    vec3_t dir;
  } ray_vec_t;

  typedef struct packed {
    pixel_id_t pixel_id;
    ray_vec_t  ray_vec;
  } prg_ray_t;

  typedef struct packed {
    ray_id_t  ray_id;
    logic     is_shadow;
    ray_vec_t ray_vec;
  } shader_to_sint_t;

endpackage

`default_nettype wire

/* shade_types_pkg.sv */
`default_nettype none

package shade_types_pkg;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } color_t;

  typedef struct packed {
    ray_types_pkg::pixel_id_t pixel_id;
    color_t                   color;
  } pixel_buffer_entry_t;

  // one record per source report, arbiter payload
  typedef struct packed {
    ray_types_pkg::ray_id_t ray_id;
    ray_types_pkg::tri_id_t tri_id;
    logic                   is_hit;
  } result_t;

endpackage

`default_nettype wire

/* valid_stall_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module valid_stall_fifo #(
  parameter type T = logic [7:0],
  parameter int DEPTH = 4
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           we,
  input  T                               data_in,
  input  logic                           re,
  output T                               data_out,
  output logic                           empty,
  output logic                           full,
  output logic [$clog2(DEPTH+1)-1:0]     count
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH+1);

  T mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;

  // show-ahead, head entry always visible
  assign data_out = mem[rd_ptr];
  assign empty    = (count == '0);
  assign full     = (count == CW'(DEPTH));

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (we) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (re) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({we, re})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) full |-> !we)
    else $error("fifo write while full");
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) empty |-> !re)
    else $error("fifo read while empty");

endmodule

`default_nettype wire

/* result_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module result_arbiter (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [3:0]                     valid_us,
  input  shade_types_pkg::result_t [3:0] data_us,
  output logic [3:0]                     stall_us,
  output logic                           valid_ds,
  output shade_types_pkg::result_t       data_ds,
  input  logic                           stall_ds
);

  logic [1:0] last_q;
  logic [1:0] gnt_idx;
  logic       gnt_any;
  logic       load;

  // output register free or draining this cycle
  assign load = ~valid_ds | ~stall_ds;

  // ------------------------------
  // round-robin pick, starting after last grant
  always_comb begin
    logic [1:0] idx;
    gnt_any = 1'b0;
    gnt_idx = last_q;
    for (int k = 1; k <= 4; k++) begin
      idx = 2'(last_q + k);
      if (!gnt_any && valid_us[idx]) begin
        gnt_any = 1'b1;
        gnt_idx = idx;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      stall_us[i] = ~(load & gnt_any & (gnt_idx == 2'(i)));
    end
  end

  // ------------------------------
  // registered output stage
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_ds <= 1'b0;
      last_q   <= 2'd3;
    end else if (load) begin
      valid_ds <= gnt_any;
      if (gnt_any) begin
        last_q <= gnt_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load && gnt_any) begin
      data_ds <= data_us[gnt_idx];
    end
  end

  // a stalled source keeps its request up until granted
  a_hold_request: assert property (@(posedge clk) disable iff (rst)
    (valid_us & stall_us) != 4'b0000 |=> ($past(valid_us & stall_us) & ~valid_us) == 4'b0000)
    else $error("source dropped its request while stalled");

endmodule

`default_nettype wire

/* ray_id_allocator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "shader_defines.svh"

module ray_id_allocator (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   alloc,
  output ray_types_pkg::ray_id_t alloc_id,
  output logic                   avail,
  input  logic                   free_we,
  input  ray_types_pkg::ray_id_t free_id,
  output logic                   ready
);

  import ray_types_pkg::*;

  logic    is_init;
  ray_id_t init_cnt;
  ray_id_t fifo_in;
  logic    fifo_we;
  logic    fifo_empty;

  // ------------------------------
  // init walk over every ray slot
  always_ff @(posedge clk) begin
    if (rst) begin
      is_init  <= 1'b1;
      init_cnt <= '0;
    end else if (is_init) begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == ray_id_t'(`NUM_RAYS - 1)) begin
        is_init <= 1'b0;
      end
    end
  end

  assign ready   = ~is_init;
  assign fifo_in = is_init ? init_cnt : free_id;
  assign fifo_we = is_init | free_we;
  // no ids handed out until the list is complete
  assign avail   = ready & ~fifo_empty;

  valid_stall_fifo #(
    .T     (ray_id_t),
    .DEPTH (`NUM_RAYS)
  ) free_list (
    .clk,
    .rst,
    .we       (fifo_we),
    .data_in  (fifo_in),
    .re       (alloc),
    .data_out (alloc_id),
    .empty    (fifo_empty),
    .full     (),
    .count    ()
  );

  a_free_after_init: assert property (@(posedge clk) disable iff (rst) !ready |-> !free_we)
    else $error("ray id returned during init");

endmodule

`default_nettype wire

/* simple_shader_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "shader_defines.svh"

module simple_shader_unit (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                prg_to_shader_valid,
  input  ray_types_pkg::prg_ray_t             prg_to_shader_data,
  output logic                                prg_to_shader_stall,
  input  logic                                pcalc_to_shader_valid,
  input  ray_types_pkg::ray_id_t              pcalc_to_shader_ray_id,
  input  ray_types_pkg::tri_id_t              pcalc_to_shader_tri_id,
  output logic                                pcalc_to_shader_stall,
  input  logic                                int_to_shader_valid,
  input  ray_types_pkg::ray_id_t              int_to_shader_ray_id,
  output logic                                int_to_shader_stall,
  input  logic                                sint_to_shader_valid,
  input  ray_types_pkg::ray_id_t              sint_to_shader_ray_id,
  output logic                                sint_to_shader_stall,
  input  logic                                ss_to_shader_valid,
  input  ray_types_pkg::ray_id_t              ss_to_shader_ray_id,
  output logic                                ss_to_shader_stall,
  output logic                                pb_we,
  input  logic                                pb_full,
  output shade_types_pkg::pixel_buffer_entry_t pb_data_out,
  output logic                                shader_to_sint_valid,
  output ray_types_pkg::shader_to_sint_t      shader_to_sint_data,
  input  logic                                shader_to_sint_stall,
  output logic                                raystore_we,
  output ray_types_pkg::ray_id_t              raystore_write_addr,
  output ray_types_pkg::ray_vec_t             raystore_write_data
);

  import ray_types_pkg::*;
  import shade_types_pkg::*;

  localparam int QCW = $clog2(`RESULT_FIFO_DEPTH + 1);

  typedef struct packed {
    pixel_id_t pixel_id;
    tri_id_t   tri_id;
    logic      is_hit;
  } shade_rec_t;

  function automatic color_t calc_color(input logic is_hit, input tri_id_t tri_id);
    color_t c;
    if (!is_hit) begin
      c = `MISS_COLOR;
    end else begin
      case (tri_id)
        16'd0:   c = `TRI_0_COLOR;
        16'd1:   c = `TRI_1_COLOR;
        16'd2:   c = `TRI_2_COLOR;
        16'd3:   c = `TRI_3_COLOR;
        default: c = `OTHER_HIT_COLOR;
      endcase
    end
    return c;
  endfunction

  ray_id_t    alloc_id;
  logic       id_avail;
  logic       ids_ready;
  logic       issue;
  pixel_id_t  pix_mem [`NUM_RAYS];
  logic [3:0] arb_valid_us;
  logic [3:0] arb_stall_us;
  result_t [3:0] arb_data_us;
  logic       arb_valid_ds;
  logic       arb_stall_ds;
  result_t    arb_data_ds;
  logic       arb_accept;
  logic       pipe_stall;
  logic       s2_valid;
  shade_rec_t s2_rec;
  shade_rec_t q_out;
  logic       q_empty;
  logic       q_re;
  logic [QCW-1:0] q_count;
  logic [QCW:0]   q_level;

  // ------------------------------
  // prg side, forwarded in the same cycle
  assign prg_to_shader_stall  = shader_to_sint_stall | ~id_avail;
  assign shader_to_sint_valid = prg_to_shader_valid & id_avail;
  assign issue                = prg_to_shader_valid & ~prg_to_shader_stall;

  always_comb begin
    shader_to_sint_data.ray_id    = alloc_id;
    shader_to_sint_data.is_shadow = 1'b0;
    shader_to_sint_data.ray_vec   = prg_to_shader_data.ray_vec;
  end

  assign raystore_we         = issue;
  assign raystore_write_addr = alloc_id;
  assign raystore_write_data = prg_to_shader_data.ray_vec;

  // pixel memory, one entry per ray slot
  always_ff @(posedge clk) begin
    if (issue) begin
      pix_mem[alloc_id] <= prg_to_shader_data.pixel_id;
    end
  end

  ray_id_allocator id_alloc (
    .clk,
    .rst,
    .alloc    (issue),
    .alloc_id (alloc_id),
    .avail    (id_avail),
    .free_we  (arb_accept),
    .free_id  (arb_data_ds.ray_id),
    .ready    (ids_ready)
  );

  // ------------------------------
  // sources into result records
  // int counts as a hit, sint and ss as misses
  always_comb begin
    arb_valid_us = {ss_to_shader_valid, sint_to_shader_valid,
                    int_to_shader_valid, pcalc_to_shader_valid};
    arb_data_us[0] = '{ray_id: pcalc_to_shader_ray_id, tri_id: pcalc_to_shader_tri_id,
                       is_hit: 1'b1};
    arb_data_us[1] = '{ray_id: int_to_shader_ray_id, tri_id: '0, is_hit: 1'b1};
    arb_data_us[2] = '{ray_id: sint_to_shader_ray_id, tri_id: '0, is_hit: 1'b0};
    arb_data_us[3] = '{ray_id: ss_to_shader_ray_id, tri_id: '0, is_hit: 1'b0};
  end

  assign pcalc_to_shader_stall = arb_stall_us[0];
  assign int_to_shader_stall   = arb_stall_us[1];
  assign sint_to_shader_stall  = arb_stall_us[2];
  assign ss_to_shader_stall    = arb_stall_us[3];

  result_arbiter arb (
    .clk,
    .rst,
    .valid_us (arb_valid_us),
    .data_us  (arb_data_us),
    .stall_us (arb_stall_us),
    .valid_ds (arb_valid_ds),
    .data_ds  (arb_data_ds),
    .stall_ds (arb_stall_ds)
  );

  // ------------------------------
  // pixel read stage, then queue
  // stage 2 always drains, so hold off while it might not fit
  assign q_level      = {1'b0, q_count} + (QCW+1)'(s2_valid);
  assign pipe_stall   = q_level >= (QCW+1)'(`RESULT_FIFO_DEPTH);
  assign arb_stall_ds = arb_valid_ds & (pipe_stall | ~ids_ready);
  assign arb_accept   = arb_valid_ds & ~arb_stall_ds;

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= arb_accept;
    end
  end

  always_ff @(posedge clk) begin
    if (arb_accept) begin
      s2_rec.pixel_id <= pix_mem[arb_data_ds.ray_id];
      s2_rec.tri_id   <= arb_data_ds.tri_id;
      s2_rec.is_hit   <= arb_data_ds.is_hit;
    end
  end

  valid_stall_fifo #(
    .T     (shade_rec_t),
    .DEPTH (`RESULT_FIFO_DEPTH)
  ) ray_data_q (
    .clk,
    .rst,
    .we       (s2_valid),
    .data_in  (s2_rec),
    .re       (q_re),
    .data_out (q_out),
    .empty    (q_empty),
    .full     (),
    .count    (q_count)
  );

  // pixel buffer output
  assign q_re  = ~q_empty & ~pb_full;
  assign pb_we = q_re;

  always_comb begin
    pb_data_out.pixel_id = q_out.pixel_id;
    pb_data_out.color    = calc_color(q_out.is_hit, q_out.tri_id);
  end

endmodule

`default_nettype wire

/* ray_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "shader_defines.svh"

module ray_store (
  input  logic                    clk,
  input  logic                    we,
  input  ray_types_pkg::ray_id_t  waddr,
  input  ray_types_pkg::ray_vec_t wdata,
  input  ray_types_pkg::ray_id_t  raddr,
  output ray_types_pkg::ray_vec_t rdata
);

  import ray_types_pkg::*;

  // one vector per ray slot
  ray_vec_t mem [`NUM_RAYS];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, data one cycle after raddr
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

/* shader_top.sv */
`timescale 1ns/1ps
`default_nettype none

module shader_top (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 prg_to_shader_valid,
  input  ray_types_pkg::prg_ray_t              prg_to_shader_data,
  output logic                                 prg_to_shader_stall,
  input  logic                                 pcalc_to_shader_valid,
  input  ray_types_pkg::ray_id_t               pcalc_to_shader_ray_id,
  input  ray_types_pkg::tri_id_t               pcalc_to_shader_tri_id,
  output logic                                 pcalc_to_shader_stall,
  input  logic                                 int_to_shader_valid,
  input  ray_types_pkg::ray_id_t               int_to_shader_ray_id,
  output logic                                 int_to_shader_stall,
  input  logic                                 sint_to_shader_valid,
  input  ray_types_pkg::ray_id_t               sint_to_shader_ray_id,
  output logic                                 sint_to_shader_stall,
  input  logic                                 ss_to_shader_valid,
  input  ray_types_pkg::ray_id_t               ss_to_shader_ray_id,
  output logic                                 ss_to_shader_stall,
  output logic                                 pb_we,
  input  logic                                 pb_full,
  output shade_types_pkg::pixel_buffer_entry_t pb_data_out,
  output logic                                 shader_to_sint_valid,
  output ray_types_pkg::shader_to_sint_t       shader_to_sint_data,
  input  logic                                 shader_to_sint_stall,
  input  ray_types_pkg::ray_id_t               rs_raddr,
  output ray_types_pkg::ray_vec_t              rs_rdata
);

  import ray_types_pkg::*;

  logic     raystore_we;
  ray_id_t  raystore_write_addr;
  ray_vec_t raystore_write_data;

  simple_shader_unit shader (
    .clk,
    .rst,
    .prg_to_shader_valid,
    .prg_to_shader_data,
    .prg_to_shader_stall,
    .pcalc_to_shader_valid,
    .pcalc_to_shader_ray_id,
    .pcalc_to_shader_tri_id,
    .pcalc_to_shader_stall,
    .int_to_shader_valid,
    .int_to_shader_ray_id,
    .int_to_shader_stall,
    .sint_to_shader_valid,
    .sint_to_shader_ray_id,
    .sint_to_shader_stall,
    .ss_to_shader_valid,
    .ss_to_shader_ray_id,
    .ss_to_shader_stall,
    .pb_we,
    .pb_full,
    .pb_data_out,
    .shader_to_sint_valid,
    .shader_to_sint_data,
    .shader_to_sint_stall,
    .raystore_we,
    .raystore_write_addr,
    .raystore_write_data
  );

  // ray vectors for the intersection side
  ray_store rs (
    .clk,
    .we    (raystore_we),
    .waddr (raystore_write_addr),
    .wdata (raystore_write_data),
    .raddr (rs_raddr),
    .rdata (rs_rdata)
  );

endmodule

`default_nettype wire

/* tb_shader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "shader_defines.svh"

module tb_shader;

  import ray_types_pkg::*;
  import shade_types_pkg::*;

  localparam int NUM_TESTS   = 6;
  localparam int RAY_WAIT    = 100;
  localparam int RESULT_WAIT = 200;
  localparam int DRAIN_WAIT  = 200;

  logic                clk;
  logic                rst;
  logic                prg_to_shader_valid;
  prg_ray_t            prg_to_shader_data;
  logic                prg_to_shader_stall;
  logic                pcalc_to_shader_valid;
  ray_id_t             pcalc_to_shader_ray_id;
  tri_id_t             pcalc_to_shader_tri_id;
  logic                pcalc_to_shader_stall;
  logic                int_to_shader_valid;
  ray_id_t             int_to_shader_ray_id;
  logic                int_to_shader_stall;
  logic                sint_to_shader_valid;
  ray_id_t             sint_to_shader_ray_id;
  logic                sint_to_shader_stall;
  logic                ss_to_shader_valid;
  ray_id_t             ss_to_shader_ray_id;
  logic                ss_to_shader_stall;
  logic                pb_we;
  logic                pb_full;
  pixel_buffer_entry_t pb_data_out;
  logic                shader_to_sint_valid;
  shader_to_sint_t     shader_to_sint_data;
  logic                shader_to_sint_stall;
  ray_id_t             rs_raddr;
  ray_vec_t            rs_rdata;

  // reference model state
  ray_id_t             free_q [$];
  pixel_id_t           pix_of [`NUM_RAYS];
  ray_vec_t            vec_of [`NUM_RAYS];
  pixel_buffer_entry_t exp_q [$];
  pixel_buffer_entry_t got_q [$];
  int                  last_src;
  int                  err_count;
  int                  tests_failed;

  shader_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (NUM_TESTS * 2000) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", NUM_TESTS * 2000);
    $display("Test failed");
    $finish;
  end

  // ------------------------------
  // compare tasks
  task automatic check_ray_id(input string name, input ray_id_t exp, input ray_id_t got);
    if (got !== exp) begin
      $display("ERR %s expected %h got %h", name, exp, got);
      err_count++;
    end
  endtask

  task automatic check_ray_vec(input string name, input ray_vec_t exp, input ray_vec_t got);
    if (got !== exp) begin
      $display("ERR %s expected %h got %h", name, exp, got);
      err_count++;
    end
  endtask

  task automatic check_pixel_entry(input string name, input pixel_buffer_entry_t exp,
                                   input pixel_buffer_entry_t got);
    if (got !== exp) begin
      $display("ERR %s expected %h got %h", name, exp, got);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("ERR %s expected %h got %h", name, exp, got);
      err_count++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int got);
    if (got != exp) begin
      $display("ERR %s expected %h got %h", name, exp, got);
      err_count++;
    end
  endtask

  // pixel buffer model, sampled mid-cycle
  always @(negedge clk) begin
    if (pb_full) begin
      check_flag("pb_we while pb_full", 1'b0, pb_we);
    end
    if (pb_we) begin
      got_q.push_back(pb_data_out);
    end
  end

  // miss, triangles 0 to 3, anything else
  function automatic color_t color_for(input logic hit, input tri_id_t tri_id);
    if (!hit) begin
      return `MISS_COLOR;
    end
    if (tri_id == 16'd0) return `TRI_0_COLOR;
    if (tri_id == 16'd1) return `TRI_1_COLOR;
    if (tri_id == 16'd2) return `TRI_2_COLOR;
    if (tri_id == 16'd3) return `TRI_3_COLOR;
    return `OTHER_HIT_COLOR;
  endfunction

  function automatic logic src_stalled(input int src);
    case (src)
      0:       return pcalc_to_shader_stall;
      1:       return int_to_shader_stall;
      2:       return sint_to_shader_stall;
      default: return ss_to_shader_stall;
    endcase
  endfunction

  // ------------------------------
  // stimulus
  task automatic issue_ray(output ray_id_t id);
    pixel_id_t pix;
    ray_vec_t  vec;
    int        waited;
    logic      done;
    pix    = pixel_id_t'($urandom());
    vec    = {$urandom(), $urandom(), $urandom()};
    id     = '0;
    waited = 0;
    done   = 1'b0;
    @(posedge clk);
    prg_to_shader_valid <= 1'b1;
    prg_to_shader_data  <= '{pixel_id: pix, ray_vec: vec};
    while (!done) begin
      @(negedge clk);
      if (!prg_to_shader_stall) begin
        done = 1'b1;
        if (free_q.size() == 0) begin
          $display("ray accepted although every ray id is in use");
          err_count++;
        end else begin
          id = free_q.pop_front();
          check_flag("shader_to_sint_valid", 1'b1, shader_to_sint_valid);
          check_ray_id("shader_to_sint_data.ray_id", id, shader_to_sint_data.ray_id);
          check_flag("shader_to_sint_data.is_shadow", 1'b0, shader_to_sint_data.is_shadow);
          check_ray_vec("shader_to_sint_data.ray_vec", vec, shader_to_sint_data.ray_vec);
          pix_of[id] = pix;
          vec_of[id] = vec;
        end
      end else if (waited >= RAY_WAIT) begin
        $display("prg ray still stalled after %0d cycles", RAY_WAIT);
        err_count++;
        done = 1'b1;
      end
      waited++;
    end
    @(posedge clk);
    prg_to_shader_valid <= 1'b0;
  endtask

  task automatic send_result(input int src, input ray_id_t id, input tri_id_t tri_id);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    @(posedge clk);
    case (src)
      0: begin
        pcalc_to_shader_valid  <= 1'b1;
        pcalc_to_shader_ray_id <= id;
        pcalc_to_shader_tri_id <= tri_id;
      end
      1: begin
        int_to_shader_valid  <= 1'b1;
        int_to_shader_ray_id <= id;
      end
      2: begin
        sint_to_shader_valid  <= 1'b1;
        sint_to_shader_ray_id <= id;
      end
      default: begin
        ss_to_shader_valid  <= 1'b1;
        ss_to_shader_ray_id <= id;
      end
    endcase
    while (!done) begin
      @(negedge clk);
      if (!src_stalled(src)) begin
        done     = 1'b1;
        last_src = src;
      end else if (waited >= RESULT_WAIT) begin
        $display("result source %0d still stalled after %0d cycles", src, RESULT_WAIT);
        err_count++;
        done = 1'b1;
      end
      waited++;
    end
    @(posedge clk);
    case (src)
      0:       pcalc_to_shader_valid <= 1'b0;
      1:       int_to_shader_valid   <= 1'b0;
      2:       sint_to_shader_valid  <= 1'b0;
      default: ss_to_shader_valid    <= 1'b0;
    endcase
  endtask

  // int reports carry triangle 0, sint and ss are misses
  task automatic expect_result(input int src, input ray_id_t id, input tri_id_t tri_id);
    pixel_buffer_entry_t e;
    e.pixel_id = pix_of[id];
    e.color    = color_for(src <= 1, (src == 0) ? tri_id : 16'd0);
    exp_q.push_back(e);
    free_q.push_back(id);
  endtask

  task automatic collect_entries(input string what);
    int waited;
    int n;
    waited = 0;
    while (got_q.size() < exp_q.size() && waited < DRAIN_WAIT) begin
      @(posedge clk);
      waited++;
    end
    // extra cycles to catch duplicates
    repeat (8) @(posedge clk);
    if (got_q.size() != exp_q.size()) begin
      $display("%s: expected %0d pixel entries, saw %0d", what, exp_q.size(), got_q.size());
      err_count++;
    end
    n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
      check_pixel_entry("pb_data_out", exp_q[i], got_q[i]);
    end
    exp_q.delete();
    got_q.delete();
  endtask

  task automatic read_back_all();
    for (int i = 0; i < `NUM_RAYS; i++) begin
      @(posedge clk);
      rs_raddr <= ray_id_t'(i);
      @(posedge clk);
      @(negedge clk);
      check_ray_vec("rs_rdata", vec_of[i], rs_rdata);
    end
  endtask

  task automatic report_test(input int num, input string name, input int start_errs);
    if (err_count == start_errs) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, err_count - start_errs);
      tests_failed++;
    end
  endtask

  // ------------------------------
  // directed tests
  task automatic pool_init();
    int      start;
    int      stalled;
    logic    leaked;
    ray_id_t id;
    start   = err_count;
    stalled = 0;
    leaked  = 1'b0;
    @(negedge clk);
    while (prg_to_shader_stall && stalled < RAY_WAIT) begin
      stalled++;
      @(negedge clk);
    end
    check_count("prg stall cycles after reset", `NUM_RAYS, stalled);
    repeat (`NUM_RAYS) issue_ray(id);
    // pool is now empty
    @(posedge clk);
    prg_to_shader_valid <= 1'b1;
    prg_to_shader_data  <= '{pixel_id: 16'hbeef, ray_vec: '0};
    repeat (20) begin
      @(negedge clk);
      if (!prg_to_shader_stall) begin
        leaked = 1'b1;
      end
    end
    @(posedge clk);
    prg_to_shader_valid <= 1'b0;
    if (leaked) begin
      $display("prg accepted a ray while the ray pool was empty");
      err_count++;
    end
    report_test(1, "pool init", start);
  endtask

  task automatic store_readback();
    int start;
    start = err_count;
    read_back_all();
    report_test(2, "ray store", start);
  endtask

  task automatic color_results();
    int      start;
    int      srcs [8];
    tri_id_t tris [8];
    start = err_count;
    srcs  = '{0, 0, 0, 0, 0, 2, 3, 1};
    tris  = '{16'd0, 16'd1, 16'd2, 16'd3, 16'd9, 16'd0, 16'd0, 16'd0};
    for (int k = 0; k < 8; k++) begin
      send_result(srcs[k], ray_id_t'(k), tris[k]);
      expect_result(srcs[k], ray_id_t'(k), tris[k]);
    end
    collect_entries("coloring");
    report_test(3, "coloring", start);
  endtask

  task automatic round_robin_share();
    int      start;
    int      first;
    int      src;
    tri_id_t tris [4];
    start = err_count;
    tris  = '{16'd2, 16'd0, 16'd0, 16'd0};
    // grant order begins after the last winner
    first = (last_src + 1) % 4;
    for (int k = 0; k < 4; k++) begin
      src = (first + k) % 4;
      expect_result(src, ray_id_t'(8 + src), tris[src]);
    end
    fork
      send_result(0, ray_id_t'(8), tris[0]);
      send_result(1, ray_id_t'(9), tris[1]);
      send_result(2, ray_id_t'(10), tris[2]);
      send_result(3, ray_id_t'(11), tris[3]);
    join
    collect_entries("arbitration");
    report_test(4, "arbitration", start);
  endtask

  task automatic pb_backpressure();
    int      start;
    int      srcs [6];
    tri_id_t tris [6];
    ray_id_t ids [6];
    start = err_count;
    srcs  = '{0, 1, 2, 3, 0, 1};
    tris  = '{16'd1, 16'd0, 16'd0, 16'd0, 16'd7, 16'd0};
    ids[0] = 4'd12;
    ids[1] = 4'd13;
    ids[2] = 4'd14;
    ids[3] = 4'd15;
    issue_ray(ids[4]);
    issue_ray(ids[5]);
    @(posedge clk);
    pb_full <= 1'b1;
    fork
      begin
        for (int k = 0; k < 6; k++) begin
          send_result(srcs[k], ids[k], tris[k]);
          expect_result(srcs[k], ids[k], tris[k]);
        end
      end
      begin
        repeat (40) @(posedge clk);
        check_count("pixel entries while pb_full", 0, got_q.size());
        pb_full <= 1'b0;
      end
    join
    collect_entries("back-pressure");
    report_test(5, "back-pressure", start);
  endtask

  task automatic id_recycling();
    int      start;
    ray_id_t id;
    start = err_count;
    // ids come back in the order they were freed
    repeat (`NUM_RAYS) issue_ray(id);
    read_back_all();
    report_test(6, "recycling", start);
  endtask

  // ------------------------------
  initial begin
    void'($urandom(32'hac80));
    err_count              = 0;
    tests_failed           = 0;
    last_src               = 3;
    rst                    = 1'b1;
    prg_to_shader_valid    = 1'b0;
    prg_to_shader_data     = '0;
    pcalc_to_shader_valid  = 1'b0;
    pcalc_to_shader_ray_id = '0;
    pcalc_to_shader_tri_id = '0;
    int_to_shader_valid    = 1'b0;
    int_to_shader_ray_id   = '0;
    sint_to_shader_valid   = 1'b0;
    sint_to_shader_ray_id  = '0;
    ss_to_shader_valid     = 1'b0;
    ss_to_shader_ray_id    = '0;
    pb_full                = 1'b0;
    shader_to_sint_stall   = 1'b0;
    rs_raddr               = '0;
    for (int i = 0; i < `NUM_RAYS; i++) begin
      free_q.push_back(ray_id_t'(i));
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    pool_init();
    store_readback();
    color_results();
    round_robin_share();
    pb_backpressure();
    id_recycling();
    $display("summary: %0d tests, %0d failed, %0d check errors",
             NUM_TESTS, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
ray_types_pkg.sv
shade_types_pkg.sv
valid_stall_fifo.sv
result_arbiter.sv
ray_id_allocator.sv
simple_shader_unit.sv
ray_store.sv
shader_top.sv
tb_shader.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_shader \
  -f verilog.f \
  -o tb_shader_sim

status=0
./obj_dir/tb_shader_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
